/* bus_cases.txt */
# group mask(m2 m1 m0, binary) op(R/W) addr wdata expected_rdata (hex, reads only)
# a line strobes every master in its mask; lines of one group go out on consecutive cycles
1  001 W 3 a5c3 0000
2  010 R 3 0000 a5c3
3  100 R 7 0000 0000
4  100 W 7 1234 0000
5  111 R 7 0000 1234
6  001 W 0 beef 0000
6  010 W 1 cafe 0000
6  100 W 2 0f0f 0000
7  111 R 1 0000 cafe
8  010 R 0 0000 beef
8  010 R 2 0000 0000
9  010 R 2 0000 0f0f
10 011 W 9 5555 0000
10 100 R 9 0000 5555
11 100 W f ffff 0000
11 001 R f 0000 ffff
12 001 W 4 1111 0000
12 110 R 4 0000 1111
13 001 R e 0000 0000
14 100 W 3 7e57 0000
14 100 W 3 0bad 0000
15 001 R 3 0000 7e57

/* all.f */
+incdir+.
bus_pkg.sv
bus_if.sv
bus_arbiter.sv
bus_master.sv
bus_mux.sv
reg_slave.sv
bus_top.sv
tb_bus_top.sv

/* tb_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module tb_bus_top;
    import bus_pkg::*;

    localparam int N         = `BUS_N_MASTERS;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 200;
    // req, grant, first live cycle, wait states, done
    localparam int UNCONTENDED_LAT = 4 + `BUS_WAIT_CYCLES;

    logic      clk;
    logic      reset;
    arb_vector cmd_valid;
    bus_op_e   cmd_op;
    bus_addr_t cmd_addr;
    bus_data_t cmd_wdata;
    arb_vector busy;
    arb_vector bus_grant;
    arb_vector done;
    bus_data_t rdata;

    int        n_cases;
    int        c_group  [MAX_CASES];
    arb_vector c_mask   [MAX_CASES];
    bit        c_write  [MAX_CASES];
    bus_addr_t c_addr   [MAX_CASES];
    bus_data_t c_wdata  [MAX_CASES];
    bus_data_t c_expect [MAX_CASES];
    int        c_taken  [MAX_CASES]; // masters that accepted the strobe
    int        c_err    [MAX_CASES];

    // expected state of each master
    arb_vector m_pending;
    int        m_case  [N];
    int        m_start [N];
    bus_data_t ref_mem [1 << `BUS_ADDR_W];

    int        cycle_cnt;
    int        errors;
    bit        started;
    bit        uncontended;
    bit        timed_out;
    arb_vector prev_grant;
    arb_vector prev_busy;

    bus_top bus_top_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .bus_grant (bus_grant),
        .done      (done),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic note_error(input int idx);
        errors++;
        if (idx >= 0) begin
            c_err[idx]++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act, input int idx);
        assert (exp === act) else begin
            $display("FAILED %s: expected %h, got %h (case %0d)", name, exp, act, idx);
            note_error(idx);
        end
    endtask

    task automatic require(input bit cond, input string msg, input int idx);
        assert (cond) else begin
            $display("ERROR: %s (case %0d)", msg, idx);
            note_error(idx);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    rc;
        int    grp;
        int    mask;
        int    addr;
        int    wdata;
        int    expv;
        string line;
        string op;
        n_cases = 0;
        fd = $fopen("bus_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open bus_cases.txt");
            note_error(-1);
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc <= 0 || line.getc(0) == "#") begin
                continue;
            end
            rc = $sscanf(line, "%d %b %s %h %h %h", grp, mask, op, addr, wdata, expv);
            if (rc <= 0) begin
                continue; // blank line
            end
            if (rc != 6) begin
                $display("ERROR: malformed line in case file: %s", line);
                note_error(-1);
                continue;
            end
            c_group[n_cases]  = grp;
            c_mask[n_cases]   = arb_vector'(mask);
            c_write[n_cases]  = (op == "W");
            c_addr[n_cases]   = bus_addr_t'(addr);
            c_wdata[n_cases]  = bus_data_t'(wdata);
            c_expect[n_cases] = bus_data_t'(expv);
            n_cases++;
        end
        $fclose(fd);
    endtask

    task automatic drive_line(input int idx);
        started   = 1'b1;
        cmd_valid = c_mask[idx];
        cmd_op    = c_write[idx] ? BUS_WRITE : BUS_READ;
        cmd_addr  = c_addr[idx];
        cmd_wdata = c_wdata[idx];
        for (int m = 0; m < N; m++) begin
            if (c_mask[idx][m]) begin
                if (m_pending[m]) begin
                    // still working on an earlier command, strobe is dropped
                    require(busy[m] === 1'b1,
                        $sformatf("master %0d idle while its command is unfinished", m), idx);
                end else begin
                    m_pending[m] = 1'b1;
                    m_case[m]    = idx;
                    m_start[m]   = cycle_cnt;
                    c_taken[idx]++;
                end
            end
        end
    endtask

    task automatic finish_master(input int m);
        int idx;
        idx = m_case[m];
        if (!m_pending[m]) begin
            require(1'b0, $sformatf("master %0d pulsed done with nothing outstanding", m), -1);
            return;
        end
        // same strobe cycle means fixed priority decides the order
        for (int j = 0; j < m; j++) begin
            if (m_pending[j] && m_case[j] == idx) begin
                require(1'b0, $sformatf("master %0d finished before master %0d", m, j), idx);
            end
        end
        compare_word($sformatf("busy[%0d]", m), 0, busy[m], idx);
        if (uncontended) begin
            compare_word("done latency", UNCONTENDED_LAT, cycle_cnt - m_start[m], idx);
        end
        if (c_write[idx]) begin
            ref_mem[c_addr[idx]] = c_wdata[idx];
        end else begin
            compare_word("rdata", c_expect[idx], rdata, idx);
            compare_word("rdata vs reference", ref_mem[c_addr[idx]], rdata, idx);
        end
        m_pending[m] = 1'b0;
    endtask

    task automatic observe_cycle();
        if (!started) begin
            compare_word("busy", 0, busy, -1);
            compare_word("done", 0, done, -1);
            compare_word("bus_grant", 0, bus_grant, -1);
        end
        require($onehot0(bus_grant), "more than one master granted", -1);
        require($onehot0(done), "more than one done pulse in a cycle", -1);
        if (prev_grant != NO_GRANT && done == '0) begin
            compare_word("bus_grant", prev_grant, bus_grant, -1); // held until done
        end
        if (bus_grant != NO_GRANT) begin
            require((bus_grant & busy) != '0, "grant held by a master that is not busy", -1);
        end
        for (int m = 0; m < N; m++) begin
            if (done[m]) begin
                finish_master(m);
            end else if (prev_busy[m] && !busy[m]) begin
                require(1'b0, $sformatf("busy of master %0d fell without done", m), -1);
            end else if (busy[m] && !m_pending[m]) begin
                require(1'b0, $sformatf("master %0d busy without a command", m), -1);
            end
        end
        prev_grant = bus_grant;
        prev_busy  = busy;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            observe_cycle();
        end
    end

    task automatic report_case(input int i);
        string kind;
        kind = (c_taken[i] == 0) ? ", strobe ignored" : "";
        if (c_err[i] == 0) begin
            $display("case %0d (group %0d%s): ok", i, c_group[i], kind);
        end else begin
            $display("case %0d (group %0d%s): %0d error(s)", i, c_group[i], kind, c_err[i]);
        end
    endtask

    task automatic run_group(input int first, input int last);
        int waited;
        uncontended = (first == last) && ($countones(c_mask[first]) == 1);
        for (int i = first; i <= last; i++) begin
            @(posedge clk);
            #1;
            drive_line(i);
        end
        @(posedge clk);
        #1;
        cmd_valid = '0;
        waited = 0;
        while (m_pending != '0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (m_pending != '0) begin
            $display("ERROR: group %0d got no done within %0d cycles", c_group[first], TIMEOUT);
            note_error(-1);
            timed_out = 1'b1;
        end
        for (int i = first; i <= last; i++) begin
            report_case(i);
        end
    endtask

    initial begin : stimulus
        int first;
        int last;
        int n_fail;
        reset       = 1'b1;
        cmd_valid   = '0;
        cmd_op      = BUS_READ;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        cycle_cnt   = 0;
        errors      = 0;
        started     = 1'b0;
        uncontended = 1'b0;
        timed_out   = 1'b0;
        m_pending   = '0;
        prev_grant  = '0;
        prev_busy   = '0;
        for (int a = 0; a < (1 << `BUS_ADDR_W); a++) begin
            ref_mem[a] = '0;
        end
        for (int i = 0; i < MAX_CASES; i++) begin
            c_taken[i] = 0;
            c_err[i]   = 0;
        end
        load_cases();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk); // quiet outputs checked here
        first = 0;
        while (first < n_cases && !timed_out) begin
            last = first;
            while (last + 1 < n_cases && c_group[last + 1] == c_group[first]) begin
                last++;
            end
            run_group(first, last);
            first = last + 1;
        end
        if (n_cases == 0) begin
            $display("ERROR: no cases loaded");
            errors++;
        end
        n_fail = 0;
        for (int i = 0; i < n_cases; i++) begin
            if (c_err[i] != 0) begin
                n_fail++;
            end
        end
        $display("%0d cases, %0d passed, %0d failed, %0d errors total",
                 n_cases, n_cases - n_fail, n_fail, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_top (
    input  logic               clk,
    input  logic               reset,
    input  bus_pkg::arb_vector cmd_valid,
    input  bus_pkg::bus_op_e   cmd_op,
    input  bus_pkg::bus_addr_t cmd_addr,
    input  bus_pkg::bus_data_t cmd_wdata,
    output bus_pkg::arb_vector busy,
    output bus_pkg::arb_vector bus_grant,
    output bus_pkg::arb_vector done,
    output bus_pkg::bus_data_t rdata
);
    import bus_pkg::*;

    arb_vector req_vec;
    bus_data_t master_rdata [`BUS_N_MASTERS];

    logic      slv_sel;
    bus_op_e   slv_op;
    bus_addr_t slv_addr;
    bus_data_t slv_wdata;
    bus_data_t slv_rdata;
    logic      slv_ack;

    bus_if bus_i [`BUS_N_MASTERS] ();

    bus_arbiter arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .bus_ack   (slv_ack),
        .bus_req   (req_vec),
        .bus_grant (bus_grant)
    );

    for (genvar g = 0; g < `BUS_N_MASTERS; g++) begin : g_master
        assign req_vec[g]      = bus_i[g].req;
        assign bus_i[g].grant  = bus_grant[g];

        bus_master master_i (
            .clk       (clk),
            .reset     (reset),
            .cmd_valid (cmd_valid[g]),
            .cmd_op    (cmd_op),
            .cmd_addr  (cmd_addr),
            .cmd_wdata (cmd_wdata),
            .bus       (bus_i[g]),
            .busy      (busy[g]),
            .done      (done[g]),
            .rdata     (master_rdata[g])
        );
    end

    bus_mux mux_i (
        .bus         (bus_i),
        .grant       (bus_grant),
        .sel         (slv_sel),
        .op          (slv_op),
        .addr        (slv_addr),
        .wdata       (slv_wdata),
        .slave_rdata (slv_rdata),
        .slave_ack   (slv_ack)
    );

    reg_slave slave_i (
        .clk   (clk),
        .reset (reset),
        .sel   (slv_sel),
        .op    (slv_op),
        .addr  (slv_addr),
        .wdata (slv_wdata),
        .rdata (slv_rdata),
        .ack   (slv_ack)
    );

    // lowest finishing master drives rdata
    always_comb begin
        rdata = '0;
        for (int i = `BUS_N_MASTERS - 1; i >= 0; i--) begin
            if (done[i]) begin
                rdata = master_rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

/* reg_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module reg_slave (
    input  logic               clk,
    input  logic               reset,
    input  logic               sel,
    input  bus_pkg::bus_op_e   op,
    input  bus_pkg::bus_addr_t addr,
    input  bus_pkg::bus_data_t wdata,
    output bus_pkg::bus_data_t rdata,
    output logic               ack
);
    import bus_pkg::*;

    localparam int DEPTH  = 1 << `BUS_ADDR_W;
    localparam int WAIT_W = $clog2(`BUS_WAIT_CYCLES + 2);

    bus_data_t         mem [DEPTH];
    logic [WAIT_W-1:0] wait_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack      <= 1'b0;
            wait_cnt <= '0;
            rdata    <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (ack) begin
                ack      <= 1'b0; // one-cycle pulse
                wait_cnt <= '0;
            end else if (sel) begin
                if (wait_cnt == WAIT_W'(`BUS_WAIT_CYCLES)) begin
                    ack      <= 1'b1;
                    wait_cnt <= '0;
                    rdata    <= mem[addr];
                    if (op == BUS_WRITE) begin
                        mem[addr] <= wdata;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else begin
                wait_cnt <= '0; // idle bus
            end
        end
    end

    a_ack_pulse: assert property (
        @(posedge clk) disable iff (reset)
        ack |=> !ack
    );

endmodule

`default_nettype wire

/* bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_mux (
    bus_if.bus                 bus [`BUS_N_MASTERS],
    input  bus_pkg::arb_vector grant,
    output logic               sel,
    output bus_pkg::bus_op_e   op,
    output bus_pkg::bus_addr_t addr,
    output bus_pkg::bus_data_t wdata,
    input  bus_pkg::bus_data_t slave_rdata,
    input  logic               slave_ack
);
    import bus_pkg::*;

    arb_vector req_v;
    bus_op_e   op_v    [`BUS_N_MASTERS];
    bus_addr_t addr_v  [`BUS_N_MASTERS];
    bus_data_t wdata_v [`BUS_N_MASTERS];

    for (genvar g = 0; g < `BUS_N_MASTERS; g++) begin : g_port
        assign req_v[g]   = bus[g].req;
        assign op_v[g]    = bus[g].op;
        assign addr_v[g]  = bus[g].addr;
        assign wdata_v[g] = bus[g].wdata;

        // response goes back to the granted master only
        assign bus[g].ack   = grant[g] & slave_ack;
        assign bus[g].rdata = grant[g] ? slave_rdata : '0;
    end

    always_comb begin
        op    = BUS_READ;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < `BUS_N_MASTERS; i++) begin
            if (grant[i]) begin // grant is one-hot
                op    = op_v[i];
                addr  = addr_v[i];
                wdata = wdata_v[i];
            end
        end
    end

    assign sel = |(grant & req_v);

    // sel is sampled just before the edge that raises ack
    a_ack_after_sel: assert property (@(posedge slave_ack) sel);

endmodule

`default_nettype wire

/* bus_master.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_master (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  bus_pkg::bus_op_e  cmd_op,
    input  bus_pkg::bus_addr_t cmd_addr,
    input  bus_pkg::bus_data_t cmd_wdata,
    bus_if.master             bus,
    output logic              busy,
    output logic              done,
    output bus_pkg::bus_data_t rdata
);
    import bus_pkg::*;

    logic      pending;
    logic      finish;
    bus_op_e   op_q;
    bus_addr_t addr_q;
    bus_data_t wdata_q;

    assign finish = bus.grant & bus.ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (pending && finish) begin
                pending <= 1'b0;
                done    <= 1'b1;
            end else if (!pending && cmd_valid) begin
                pending <= 1'b1;
            end
            // strobes while pending are dropped
        end
    end

    always_ff @(posedge clk) begin
        if (!pending && cmd_valid) begin
            op_q    <= cmd_op;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (pending && finish) begin
            rdata <= bus.rdata; // meaningful for reads only
        end
    end

    // drop req during ack so the arbiter does not regrant us on that edge
    assign bus.req   = pending & ~finish;
    assign bus.op    = op_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    assign busy = pending;

    a_cmd_locked: assert property (
        @(posedge clk) disable iff (reset)
        cmd_valid && pending |=> $stable({op_q, addr_q, wdata_q})
    );

endmodule

`default_nettype wire

/* bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               bus_ack,
    input  bus_pkg::arb_vector bus_req,
    output bus_pkg::arb_vector bus_grant
);
    import bus_pkg::*;

    arb_state_e state_q;
    arb_vector  prio_req;

    // lowest index wins, so scan downward and let the last hit stand
    always_comb begin
        prio_req = NO_GRANT;
        for (int i = `BUS_N_MASTERS - 1; i >= 0; i--) begin
            if (bus_req[i]) begin
                prio_req    = NO_GRANT;
                prio_req[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q   <= READY;
            bus_grant <= NO_GRANT;
        end else begin
            case (state_q)
                READY: begin
                    bus_grant <= prio_req; // zero when nobody asks
                    if (bus_req != NO_GRANT) begin
                        state_q <= BUSY;
                    end
                end
                BUSY: begin
                    // grant only moves on the ack of the current transfer
                    if (bus_ack) begin
                        bus_grant <= prio_req;
                        if (bus_req == NO_GRANT) begin
                            state_q <= READY;
                        end
                    end
                end
                default: begin
                    state_q   <= READY;
                    bus_grant <= NO_GRANT;
                end
            endcase
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bus_grant)
    );

    a_grant_held: assert property (
        @(posedge clk) disable iff (reset)
        (bus_grant != NO_GRANT) && !bus_ack |=> $stable(bus_grant)
    );

    // a new grant must go to a requester with no lower-index rival
    for (genvar i = 0; i < `BUS_N_MASTERS; i++) begin : g_prio_chk
        a_grant_prio: assert property (
            @(posedge clk) disable iff (reset)
            $rose(bus_grant[i]) |->
                $past(bus_req[i]) &&
                (($past(bus_req) & arb_vector'((1 << i) - 1)) == NO_GRANT)
        );
    end

endmodule

`default_nettype wire

/* bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
    import bus_pkg::*;

    logic      req;
    logic      grant;
    bus_op_e   op;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t rdata;
    logic      ack; // single-cycle pulse, only while granted

    modport master (
        output req,
        output op,
        output addr,
        output wdata,
        input  grant,
        input  rdata,
        input  ack
    );

    // grant is driven from the top-level wiring, rdata/ack by the mux
    modport bus (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output grant,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

`include "bus_config.svh"

package bus_pkg;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    typedef enum logic {
        READY,
        BUSY
    } arb_state_e;

    // one bit per master
    typedef logic [`BUS_N_MASTERS-1:0] arb_vector;

    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;

    parameter arb_vector NO_GRANT = '0;

endpackage

`default_nettype wire

/* bus_config.svh */
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// number of bus masters sharing the slave
`define BUS_N_MASTERS 3

// 16-word register file
`define BUS_ADDR_W 4

`define BUS_DATA_W 16

// slave wait states between first live cycle and ack
`define BUS_WAIT_CYCLES 1

`endif
